/* i2cPkg.sv */
// Shared bus timing constants, operation kind type and open-drain level names

`default_nettype none

package i2cPkg;

  // ------------------------------------------------
  // Bus rate
  // ------------------------------------------------
  localparam int QuarterCycles = 8; // clk cycles per quarter bit, small for simulation
  localparam int QuarterCntWidth = (QuarterCycles > 1) ? $clog2(QuarterCycles) : 1;

  // Operation lengths in quarters
  localparam int StartQuarters = 4; // Single bit time
  localparam int StopQuarters = 4;  // Single bit time
  localparam int DataWidth = 8;     // Byte width
  localparam int ByteQuarters = (DataWidth + 1) * 4; // Eight data bits plus ack, 36

  // Quarter index has to reach the last quarter of a byte
  localparam int QuarterIdxWidth = $clog2(ByteQuarters);

  // ------------------------------------------------
  // Clock stretching
  // ------------------------------------------------
  // Cycles of released-but-low SCL before the divider pauses
  localparam int StretchFilterLen = 3;
  localparam int StretchCntWidth = $clog2(StretchFilterLen + 1); // Counts up to the limit

  // Operation kinds the master can run
  typedef enum logic [1:0] {
    OpStart = 2'd0, // Start condition
    OpStop  = 2'd1, // Stop condition
    OpByte  = 2'd2  // Byte write with ack
  } OpKind_t;

  // Open-drain levels, never driven high on the pad
  localparam logic LineReleased = 1'b1;
  localparam logic LinePulled = 1'b0;

endpackage

`default_nettype wire

/* i2cCmdDecode.sv */
// Command strobe decode, active operation tracking and bus-master flag

`timescale 1ns/1ps
`default_nettype none

module i2cCmdDecode import i2cPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 startStrb_i,  // Request start condition
  input  logic                 stopStrb_i,   // Request stop condition
  input  logic                 txStrb_i,     // Request byte write
  input  logic [DataWidth-1:0] txData_i,     // Byte for the write
  input  logic                 opDone_i,     // Operation finished, from timer
  output OpKind_t              opKind_o,     // Kind of the running operation
  output logic                 opActive_o,   // Operation in flight
  output logic                 opLaunch_o,   // Pulse when accepted
  output logic [DataWidth-1:0] txByte_o,     // Byte held for the whole write
  output logic                 busMaster_o   // We own the bus
);

  logic    anyStrb;   // Some command requested
  logic    accept;    // Request taken this cycle
  OpKind_t nextKind;  // Kind after priority

  // ------------------------------------------------
  // Accept logic
  // ------------------------------------------------
  assign anyStrb = startStrb_i | stopStrb_i | txStrb_i;
  assign accept  = anyStrb & ~opActive_o; // Busy drops strobes on the floor

  // Stop wins over start, start over byte
  always_comb begin
    if (stopStrb_i)
      nextKind = OpStop;
    else if (startStrb_i)
      nextKind = OpStart;
    else
      nextKind = OpByte;
  end

  // Kind, active level and launch pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      opKind_o   <= OpStart;
      opActive_o <= 1'b0;
      opLaunch_o <= 1'b0;
    end else begin
      opLaunch_o <= accept; // One cycle after the strobe
      if (accept) begin
        opKind_o   <= nextKind;
        opActive_o <= 1'b1;
      end else if (opDone_i) begin
        opActive_o <= 1'b0; // Low the cycle after done
      end
    end
  end

  // Byte is only captured for a write
  always_ff @(posedge clk) begin
    if (accept && nextKind == OpByte)
      txByte_o <= txData_i;
  end

  // Bus ownership from start launch to stop completion
  always_ff @(posedge clk) begin
    if (reset)
      busMaster_o <= 1'b0;
    else if (accept && nextKind == OpStart)
      busMaster_o <= 1'b1;
    else if (opDone_i && opKind_o == OpStop)
      busMaster_o <= 1'b0; // Released only once stop is on the wire
  end

endmodule

`default_nettype wire

/* i2cBitTimer.sv */
// Quarter-bit divider, quarter index, SCL pattern, stretch filter and operation end

`timescale 1ns/1ps
`default_nettype none

module i2cBitTimer import i2cPkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  OpKind_t                    opKind_i,      // Running operation kind
  input  logic                       opActive_i,    // Operation in flight
  input  logic                       opLaunch_i,    // Operation accepted
  input  logic                       sclIn_i,       // SCL as seen on the bus
  output logic                       sclOut_o,      // SCL drive, 1 is released
  output logic                       quarterTick_o, // End of a quarter
  output logic [QuarterIdxWidth-1:0] quarterIdx_o,  // Current quarter of the op
  output logic                       opDone_o       // Pulse after the last quarter
);

  logic [QuarterCntWidth-1:0] divCnt;      // Cycles within the quarter
  logic [StretchCntWidth-1:0] stretchCnt;  // Consecutive stretched cycles
  logic [QuarterIdxWidth-1:0] lastIdx;     // Final quarter for this kind
  logic                       running;     // Quarters are being timed
  logic                       sclHeldLow;  // Slave holding SCL against us
  logic                       stalled;     // Divider frozen
  logic                       lastQuarter; // In the final quarter
  logic                       sclNext;     // SCL level for current quarter

  // Not in the launch cycle, and not once done has fired
  assign running = opActive_i & ~opLaunch_i & ~opDone_o;

  // ------------------------------------------------
  // Stretch filter
  // ------------------------------------------------
  // We let go of SCL but it still reads low
  assign sclHeldLow = (sclOut_o == LineReleased) && (sclIn_i == LinePulled);
  assign stalled    = (stretchCnt == StretchCntWidth'(StretchFilterLen));

  always_ff @(posedge clk) begin
    if (reset)
      stretchCnt <= '0;
    else if (!sclHeldLow)
      stretchCnt <= '0;              // Any high reading restarts the filter
    else if (!stalled)
      stretchCnt <= stretchCnt + 1'b1; // Saturates at the limit
  end

  // ------------------------------------------------
  // Quarter divider
  // ------------------------------------------------
  assign quarterTick_o = running & ~stalled &
                         (divCnt == QuarterCntWidth'(QuarterCycles - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      divCnt <= '0;
    end else if (opLaunch_i) begin
      divCnt <= '0; // Quarter 0 starts next cycle
    end else if (running && !stalled) begin
      if (quarterTick_o)
        divCnt <= '0;
      else
        divCnt <= divCnt + 1'b1;
    end
  end

  // Length of each operation kind
  always_comb begin
    case (opKind_i)
      OpStart: lastIdx = QuarterIdxWidth'(StartQuarters - 1);
      OpStop:  lastIdx = QuarterIdxWidth'(StopQuarters - 1);
      default: lastIdx = QuarterIdxWidth'(ByteQuarters - 1);
    endcase
  end

  assign lastQuarter = (quarterIdx_o == lastIdx);

  // Quarter index, held at the last quarter after the final tick
  always_ff @(posedge clk) begin
    if (reset)
      quarterIdx_o <= '0;
    else if (opLaunch_i)
      quarterIdx_o <= '0;
    else if (quarterTick_o && !lastQuarter)
      quarterIdx_o <= quarterIdx_o + 1'b1;
  end

  // Done one cycle after the last quarter ends
  always_ff @(posedge clk) begin
    if (reset)
      opDone_o <= 1'b0;
    else
      opDone_o <= quarterTick_o & lastQuarter;
  end

  // ------------------------------------------------
  // SCL pattern
  // ------------------------------------------------
  always_comb begin
    case (opKind_i)
      // High for the SDA fall, then low
      OpStart: sclNext = (quarterIdx_o < QuarterIdxWidth'(2)) ? LineReleased : LinePulled;
      // Low one quarter, then high for the SDA rise
      OpStop:  sclNext = (quarterIdx_o == '0) ? LinePulled : LineReleased;
      // Low in first half of the bit, high in second half
      default: sclNext = quarterIdx_o[1] ? LineReleased : LinePulled;
    endcase
  end

  // Registered drive, holds between operations
  always_ff @(posedge clk) begin
    if (reset)
      sclOut_o <= LineReleased;
    else if (running)
      sclOut_o <= sclNext;
  end

endmodule

`default_nettype wire

/* i2cSdaDriver.sv */
// SDA pattern per operation, byte shift-out and acknowledge capture

`timescale 1ns/1ps
`default_nettype none

module i2cSdaDriver import i2cPkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  OpKind_t                    opKind_i,      // Running operation kind
  input  logic                       opActive_i,    // Operation in flight
  input  logic                       opLaunch_i,    // Operation accepted
  input  logic                       quarterTick_i, // End of a quarter
  input  logic [QuarterIdxWidth-1:0] quarterIdx_i,  // Current quarter of the op
  input  logic [DataWidth-1:0]       txByte_i,      // Byte to send
  input  logic                       sdaIn_i,       // SDA as seen on the bus
  output logic                       sdaOut_o,      // SDA drive, 1 is released
  output logic                       txNack_o       // Last ack level, 1 is NACK
);

  logic [DataWidth-1:0] shiftReg; // MSB is the bit on the wire
  logic                 running;  // Pattern is being driven
  logic                 bitEnd;   // Tick that enters the next bit
  logic                 ackTick;  // Tick that enters quarter 35
  logic                 sdaNext;  // SDA level for current quarter

  assign running = opActive_i & ~opLaunch_i;

  // Bit boundary, four quarters per bit
  assign bitEnd  = quarterTick_i & (quarterIdx_i[1:0] == 2'd3);
  assign ackTick = quarterTick_i & (quarterIdx_i == QuarterIdxWidth'(ByteQuarters - 2));

  // ------------------------------------------------
  // Byte shift-out
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (opLaunch_i)
      shiftReg <= txByte_i;
    else if (bitEnd && opKind_i == OpByte)
      // Released level fills in, so bit 8 leaves SDA free for the ack
      shiftReg <= {shiftReg[DataWidth-2:0], LineReleased};
  end

  // ------------------------------------------------
  // SDA pattern
  // ------------------------------------------------
  always_comb begin
    case (opKind_i)
      // Falls in quarter 1 while SCL is still high
      OpStart: sdaNext = (quarterIdx_i == '0) ? LineReleased : LinePulled;
      // Rises in quarter 2 after SCL went high
      OpStop:  sdaNext = (quarterIdx_i < QuarterIdxWidth'(2)) ? LinePulled : LineReleased;
      default: sdaNext = shiftReg[DataWidth-1];
    endcase
  end

  // Registered drive, lags the index like SCL does
  always_ff @(posedge clk) begin
    if (reset)
      sdaOut_o <= LineReleased;
    else if (running)
      sdaOut_o <= sdaNext;
  end

  // ------------------------------------------------
  // Acknowledge capture
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      txNack_o <= 1'b0;
    else if (opLaunch_i)
      txNack_o <= 1'b0; // Fresh result per operation
    else if (ackTick && opKind_i == OpByte)
      txNack_o <= sdaIn_i; // Sampled mid high phase of bit 8
  end

endmodule

`default_nettype wire

/* i2cMaster.sv */
// Two-wire bus master top level with command decode, bit timer and SDA driver

`timescale 1ns/1ps
`default_nettype none

module i2cMaster import i2cPkg::*; (
  input  logic                 clk,
  input  logic                 reset,

  // Command side
  input  logic                 startStrb_i,  // Start condition request
  input  logic                 stopStrb_i,   // Stop condition request
  input  logic                 txStrb_i,     // Byte write request
  input  logic [DataWidth-1:0] txData_i,     // Byte to write
  output logic                 txDone_o,     // Operation complete pulse
  output logic                 txNack_o,     // No ack on last byte
  output logic                 busMaster_o,  // Bus owned

  // Open-drain lines, 1 released and 0 pulled
  input  logic                 sclIn_i,
  input  logic                 sdaIn_i,
  output logic                 sclOut_o,
  output logic                 sdaOut_o
);

  OpKind_t                    opKind;      // Running operation
  logic                       opActive;    // Operation in flight
  logic                       opLaunch;    // Operation accepted
  logic [DataWidth-1:0]       txByte;      // Held write byte
  logic                       quarterTick; // Quarter boundary
  logic [QuarterIdxWidth-1:0] quarterIdx;  // Quarter within the op

  // ------------------------------------------------
  // Decode
  // ------------------------------------------------
  i2cCmdDecode u_cmdDecode (
    .clk         (clk),
    .reset       (reset),
    .startStrb_i (startStrb_i),
    .stopStrb_i  (stopStrb_i),
    .txStrb_i    (txStrb_i),
    .txData_i    (txData_i),
    .opDone_i    (txDone_o),   // Done pulse closes the operation
    .opKind_o    (opKind),
    .opActive_o  (opActive),
    .opLaunch_o  (opLaunch),
    .txByte_o    (txByte),
    .busMaster_o (busMaster_o)
  );

  // ------------------------------------------------
  // Timing and SCL
  // ------------------------------------------------
  i2cBitTimer u_bitTimer (
    .clk           (clk),
    .reset         (reset),
    .opKind_i      (opKind),
    .opActive_i    (opActive),
    .opLaunch_i    (opLaunch),
    .sclIn_i       (sclIn_i),
    .sclOut_o      (sclOut_o),
    .quarterTick_o (quarterTick),
    .quarterIdx_o  (quarterIdx),
    .opDone_o      (txDone_o)
  );

  // SDA and ack result
  i2cSdaDriver u_sdaDriver (
    .clk           (clk),
    .reset         (reset),
    .opKind_i      (opKind),
    .opActive_i    (opActive),
    .opLaunch_i    (opLaunch),
    .quarterTick_i (quarterTick),
    .quarterIdx_i  (quarterIdx),
    .txByte_i      (txByte),
    .sdaIn_i       (sdaIn_i),
    .sdaOut_o      (sdaOut_o),
    .txNack_o      (txNack_o)
  );

endmodule

`default_nettype wire

/* i2cMasterTb.sv */
// Testbench for the bus master with clock, stimulus, stretching slave model and assertions

`timescale 1ns/1ps
`default_nettype none

module i2cMasterTb import i2cPkg::*; ();

  localparam int ClkPeriod    = 8;
  localparam int ResetCycles  = 10;
  localparam int NumTrans     = 20;
  localparam int MaxBytes     = 4;
  localparam int MaxExtraHold = 20;                              // Stretch past the low phase
  localparam int MaxHold      = 2 * QuarterCycles + MaxExtraHold; // Slave busy time per bit
  localparam int TransCycles  = (StartQuarters + StopQuarters + MaxBytes * ByteQuarters)
                                * QuarterCycles + (MaxBytes * (DataWidth + 1) + 2) * MaxHold;
  localparam longint WatchdogNs = longint'(4 * NumTrans * TransCycles + ResetCycles) * ClkPeriod;

  logic                 clk;
  logic                 reset;
  logic                 startStrb, stopStrb, txStrb;
  logic [DataWidth-1:0] txData;
  logic                 txDone, txNack, busMaster;
  logic                 sclOut, sdaOut;
  logic                 sclBus, sdaBus;         // Wired lines seen by both sides
  logic                 slaveScl = LineReleased;
  logic                 slaveSda = LineReleased;
  logic                 inByte = 1'b0;          // Byte op on the wire

  // Slave and monitor state
  logic                 prevScl = LineReleased;
  logic                 prevSda = LineReleased;
  logic [DataWidth-1:0] shiftIn = '0;
  logic [DataWidth-1:0] rxByte = '0;            // Last byte the slave assembled
  logic                 ackChoice = 1'b0;       // 1 means slave acked
  int bitCnt = 0, holdLeft = 0;
  int startCount = 0, stopCount = 0, rxCount = 0, doneCount = 0;
  int heldRun = 0, heldLowTotal = 0, stretchDelay = 0;
  int checks = 0, errors = 0, cmdCount = 0;

  // Pull-up wins unless a side pulls the line
  assign sclBus = (sclOut === LinePulled || slaveScl === LinePulled) ? LinePulled : LineReleased;
  assign sdaBus = (sdaOut === LinePulled || slaveSda === LinePulled) ? LinePulled : LineReleased;

  i2cMaster u_i2cMaster (
    .clk         (clk),
    .reset       (reset),
    .startStrb_i (startStrb),
    .stopStrb_i  (stopStrb),
    .txStrb_i    (txStrb),
    .txData_i    (txData),
    .txDone_o    (txDone),
    .txNack_o    (txNack),
    .busMaster_o (busMaster),
    .sclIn_i     (sclBus),
    .sdaIn_i     (sdaBus),
    .sclOut_o    (sclOut),
    .sdaOut_o    (sdaOut)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // ------------------------------------------------
  // Behavioral slave, acts on the falling clk edge
  // ------------------------------------------------
  always @(negedge clk) begin : slaveModel
    logic ackNow;
    prevScl <= sclBus;
    prevSda <= sdaBus;
    if (!reset) begin
      if (prevScl && sclBus && prevSda && !sdaBus) begin
        startCount <= startCount + 1; // SDA fell with SCL high
        bitCnt     <= 0;
      end else if (prevScl && sclBus && !prevSda && sdaBus) begin
        stopCount <= stopCount + 1;   // SDA rose with SCL high
        bitCnt    <= 0;
      end
      if (!prevScl && sclBus) begin   // Rising SCL, sample a bit
        shiftIn <= {shiftIn[DataWidth-2:0], sdaBus};
        if (bitCnt == DataWidth - 1) begin
          rxByte  <= {shiftIn[DataWidth-2:0], sdaBus};
          rxCount <= rxCount + 1;
        end
        bitCnt <= bitCnt + 1;
      end
      if (prevScl && !sclBus) begin   // Falling SCL
        if (bitCnt == DataWidth) begin
          ackNow    = ($urandom_range(0, 1) == 1);
          ackChoice <= ackNow;
          slaveSda  <= ackNow ? LinePulled : LineReleased; // Ninth bit
        end else if (bitCnt == DataWidth + 1) begin
          slaveSda <= LineReleased;
          bitCnt   <= 0;
        end
        if ($urandom_range(0, 3) == 0) begin
          slaveScl <= LinePulled;     // Busy, hold the clock
          holdLeft <= 2 * QuarterCycles + $urandom_range(0, MaxExtraHold);
        end
      end else if (slaveScl == LinePulled) begin
        if (holdLeft <= 1)
          slaveScl <= LineReleased;
        else
          holdLeft <= holdLeft - 1;
      end
    end
  end

  // Done pulses and stretch cycles that can freeze the divider
  always @(negedge clk) begin
    if (!reset && txDone)
      doneCount <= doneCount + 1;
    if (!reset && sclOut == LineReleased && sclBus == LinePulled) begin
      heldRun      <= heldRun + 1;
      heldLowTotal <= heldLowTotal + 1;
    end else begin
      if (heldRun > StretchFilterLen)
        stretchDelay <= stretchDelay + heldRun - StretchFilterLen; // Lower bound
      heldRun <= 0;
    end
  end

  // ------------------------------------------------
  // Concurrent checks
  // ------------------------------------------------
  doneSinglePulse: assert property (@(posedge clk) disable iff (reset) txDone |=> !txDone)
    else begin
      errors++;
      $display("[FAIL] txDone: pulse longer than one cycle at %0t", $time);
    end

  // Data may only move while SCL is low
  sdaStableHigh: assert property (@(posedge clk) disable iff (reset)
      (inByte && sclBus && $past(sclBus)) |-> (sdaBus == $past(sdaBus)))
    else begin
      errors++;
      $display("[FAIL] sdaBus: changed while SCL high during a byte at %0t", $time);
    end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  task automatic checkValue(input string sigName, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h at %0t", sigName, exp, got, $time);
    end
  endtask

  task automatic checkIdle();
    checkValue("sclOut", sclOut, LineReleased);
    checkValue("sdaOut", sdaOut, LineReleased);
    checkValue("txDone", txDone, 1'b0);
    checkValue("busMaster", busMaster, 1'b0);
    checkValue("txNack", txNack, 1'b0);
  endtask

  // Strobe to done is launch, quarters and done register unless SCL was held
  task automatic checkLatency(input int cycles, input int quarters, input int heldLow,
                              input int delay);
    int nominal;
    nominal = quarters * QuarterCycles + 2;
    if (heldLow == 0) begin
      checkValue("opCycles", cycles, nominal);
    end else begin
      checks++;
      assert (cycles >= nominal + delay) else begin
        errors++;
        $display("[FAIL] opCycles: expected at least 0x%0h, got 0x%0h", nominal + delay, cycles);
      end
    end
  endtask

  // Clears the strobes and waits for done, with an optional strobe while busy
  task automatic waitDone(input int pokeAt, output int cycles);
    @(negedge clk);
    startStrb = 1'b0;
    stopStrb  = 1'b0;
    txStrb    = 1'b0;
    cycles    = 1;
    while (!txDone) begin
      @(negedge clk);
      cycles++;
      txStrb = (cycles == pokeAt); // Must be dropped
      if (cycles == pokeAt)
        txData = $urandom_range(0, 255);
    end
  endtask

  task automatic sendStart();
    int cycles, starts, stops, held, delay, dones;
    starts = startCount;
    stops  = stopCount;
    held   = heldLowTotal;
    delay  = stretchDelay;
    dones  = doneCount;
    @(negedge clk);
    startStrb = 1'b1;
    cmdCount++;
    waitDone(($urandom_range(0, 1) == 1) ? 6 : -1, cycles);
    checkValue("busMaster", busMaster, 1'b1);
    checkLatency(cycles, StartQuarters, heldLowTotal - held, stretchDelay - delay);
    @(negedge clk);
    checkValue("startCount", startCount - starts, 1);
    checkValue("stopCount", stopCount - stops, 0);
    checkValue("doneCount", doneCount - dones, 1);
  endtask

  task automatic sendByte(input logic [DataWidth-1:0] data);
    int cycles, starts, stops, rxs, held, delay, dones;
    starts = startCount;
    stops  = stopCount;
    rxs    = rxCount;
    held   = heldLowTotal;
    delay  = stretchDelay;
    dones  = doneCount;
    @(negedge clk);
    txData = data;
    txStrb = 1'b1;
    inByte = 1'b1;
    cmdCount++;
    waitDone(($urandom_range(0, 2) == 0) ? 10 : -1, cycles);
    checkLatency(cycles, ByteQuarters, heldLowTotal - held, stretchDelay - delay);
    @(negedge clk);
    inByte = 1'b0;
    checkValue("rxCount", rxCount - rxs, 1);
    checkValue("rxByte", rxByte, data);
    checkValue("txNack", txNack, !ackChoice);
    checkValue("startCount", startCount - starts, 0); // No false conditions
    checkValue("stopCount", stopCount - stops, 0);
    checkValue("doneCount", doneCount - dones, 1);
  endtask

  // A byte strobe in the same cycle loses to stop
  task automatic sendStop(input logic withByte);
    int cycles, starts, stops, rxs, held, delay, dones;
    starts = startCount;
    stops  = stopCount;
    rxs    = rxCount;
    held   = heldLowTotal;
    delay  = stretchDelay;
    dones  = doneCount;
    @(negedge clk);
    stopStrb = 1'b1;
    txStrb   = withByte;
    cmdCount++;
    waitDone(-1, cycles);
    checkLatency(cycles, StopQuarters, heldLowTotal - held, stretchDelay - delay);
    @(negedge clk);
    checkValue("stopCount", stopCount - stops, 1);
    checkValue("startCount", startCount - starts, 0);
    checkValue("rxCount", rxCount - rxs, 0);
    checkValue("busMaster", busMaster, 1'b0);
    checkValue("doneCount", doneCount - dones, 1);
    checkValue("sclBus", sclBus, LineReleased);
    checkValue("sdaBus", sdaBus, LineReleased);
  endtask

  task automatic printSummary();
    $display("Checks: %0d, errors: %0d, commands: %0d", checks, errors, cmdCount);
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    int seedVal, nBytes;
    seedVal   = $urandom(47);
    reset     = 1'b1;
    startStrb = 1'b0;
    stopStrb  = 1'b0;
    txStrb    = 1'b0;
    txData    = '0;
    repeat (ResetCycles) begin
      @(negedge clk);
      checkIdle();
    end
    reset = 1'b0;
    repeat (5) begin
      @(negedge clk);
      checkIdle();                 // Quiet until the first strobe
    end
    for (int t = 0; t < NumTrans; t++) begin
      sendStart();
      nBytes = $urandom_range(1, MaxBytes);
      for (int b = 0; b < nBytes; b++)
        sendByte($urandom_range(0, 255));
      sendStop($urandom_range(0, 3) == 0);
      repeat ($urandom_range(0, 5)) @(negedge clk);
    end
    repeat (4 * QuarterCycles) @(negedge clk);
    checkValue("doneTotal", doneCount, cmdCount); // Nothing left running
    printSummary();
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Watchdog sized from the longest possible sequence
  initial begin
    #(WatchdogNs);
    $display("Timeout: command sequence did not finish within %0d ns", WatchdogNs);
    printSummary();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
i2cPkg.sv
i2cCmdDecode.sv
i2cBitTimer.sv
i2cSdaDriver.sv
i2cMaster.sv
i2cMasterTb.sv

/* Bender.yml */
package:
  name: i2c_master

sources:
  - i2cPkg.sv
  - i2cCmdDecode.sv
  - i2cBitTimer.sv
  - i2cSdaDriver.sv
  - i2cMaster.sv
  - target: test
    files:
      - i2cMasterTb.sv
